/* hdl/hazard_unit.sv */
`timescale 1ns/1ns

module hazard_unit import idec_pkg::*; (
  input  src_t a_src,
  input  src_t b_src,
  input  logic b_need_late,
  input  src_t ex_dest,
  input  src_t mem_dest,
  input  logic ex_load,
  output fwd_t a_fwd,
  output fwd_t b_fwd,
  output logic stall
);

  logic a_hit_ex;
  logic a_hit_mem;
  logic b_hit_ex;
  logic b_hit_mem;

  assign a_hit_ex  = a_src.valid && ex_dest.valid && (a_src.num == ex_dest.num);
  assign a_hit_mem = a_src.valid && mem_dest.valid && (a_src.num == mem_dest.num);
  assign b_hit_ex  = b_src.valid && ex_dest.valid && (b_src.num == ex_dest.num);
  assign b_hit_mem = b_src.valid && mem_dest.valid && (b_src.num == mem_dest.num);

  // younger producer wins
  assign a_fwd = a_hit_ex  ? FWD_FROM_EXMEM :
                 a_hit_mem ? FWD_FROM_MEMWB :
                             FWD_NONE;

  // store data can catch the load result one stage later
  assign b_fwd = b_hit_ex  ? (ex_load ? FWD_FROM_MEMWB_LATE : FWD_FROM_EXMEM) :
                 b_hit_mem ? FWD_FROM_MEMWB :
                             FWD_NONE;

  assign stall = ex_load && (a_hit_ex || (b_hit_ex && !b_need_late));

  a_stall_needs_load: assert final (!stall || (ex_load && ex_dest.valid));

endmodule

/* hdl/idec.sv */
`timescale 1ns/1ns
`include "idec_defines.svh"

module idec import idec_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`IDEC_XLEN-1:0] inst_word,
  input  logic [`IDEC_XLEN-1:0] pc_plus_4,
  input  logic [`IDEC_XLEN-1:0] rd_data1,
  input  logic [`IDEC_XLEN-1:0] rd_data2,
  input  src_t                  ex_dest,
  input  src_t                  mem_dest,
  input  logic                  ex_load,
  output logic [`IDEC_RA-1:0]   rd_addr1,
  output logic [`IDEC_RA-1:0]   rd_addr2,
  output logic                  stall,
  output dec_ctrl_t             ctrl,
  output opnd_t                 opnd
);

  dec_ctrl_t             dec_ctrl;
  logic                  imm_sext;
  logic                  imm_valid;
  logic [`IDEC_XLEN-1:0] imm;
  fwd_t                  a_fwd;
  fwd_t                  b_fwd;
  opnd_t                 opnd_d;

  assign rd_addr1 = dec_ctrl.a_src.num;  // rs
  assign rd_addr2 = dec_ctrl.b_src.num;  // rt

  assign opnd_d = '{a: rd_data1, b: rd_data2, imm: imm, imm_valid: imm_valid,
                    a_fwd: a_fwd, b_fwd: b_fwd};

  inst_decoder inst_decoder_i (
    .inst_word (inst_word),
    .ctrl      (dec_ctrl),
    .imm_sext  (imm_sext),
    .imm_valid (imm_valid)
  );

  imm_gen imm_gen_i (
    .inst_word (inst_word),
    .pc_plus_4 (pc_plus_4),
    .jmp       (dec_ctrl.jmp_inst),
    .branch    (dec_ctrl.branch_inst),
    .sext      (imm_sext),
    .imm       (imm)
  );

  hazard_unit hazard_unit_i (
    .a_src       (dec_ctrl.a_src),
    .b_src       (dec_ctrl.b_src),
    .b_need_late (dec_ctrl.b_need_late),
    .ex_dest     (ex_dest),
    .mem_dest    (mem_dest),
    .ex_load     (ex_load),
    .a_fwd       (a_fwd),
    .b_fwd       (b_fwd),
    .stall       (stall)
  );

  stage_reg #(.payload_t(dec_ctrl_t)) ctrl_reg_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .bubble (stall),
    .d      (dec_ctrl),
    .q      (ctrl)
  );

  stage_reg #(.payload_t(opnd_t)) opnd_reg_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .bubble (stall),
    .d      (opnd_d),
    .q      (opnd)
  );

endmodule

/* hdl/idec_defines.svh */
`ifndef IDEC_DEFINES_SVH
`define IDEC_DEFINES_SVH

`define IDEC_XLEN      32
`define IDEC_RA        5
`define IDEC_LINK_REG  5'd31

// instruction fields
`define IDEC_F_OPC     31:26
`define IDEC_F_RS      25:21
`define IDEC_F_RT      20:16
`define IDEC_F_RD      15:11
`define IDEC_F_SHAMT   10:6
`define IDEC_F_FUNCT   5:0
`define IDEC_F_IMM     15:0
`define IDEC_F_ADDR    25:0

// primary opcodes
`define OPC_SPECIAL    6'h00
`define OPC_REGIMM     6'h01
`define OPC_J          6'h02
`define OPC_JAL        6'h03
`define OPC_BEQ        6'h04
`define OPC_BNE        6'h05
`define OPC_BLEZ       6'h06
`define OPC_BGTZ       6'h07
`define OPC_ADDI       6'h08
`define OPC_ADDIU      6'h09
`define OPC_SLTI       6'h0a
`define OPC_SLTIU      6'h0b
`define OPC_ANDI       6'h0c
`define OPC_ORI        6'h0d
`define OPC_XORI       6'h0e
`define OPC_LUI        6'h0f
`define OPC_LB         6'h20
`define OPC_LH         6'h21
`define OPC_LW         6'h23
`define OPC_LBU        6'h24
`define OPC_LHU        6'h25
`define OPC_SB         6'h28
`define OPC_SH         6'h29
`define OPC_SW         6'h2b

// regimm rt codes
`define OPC_RT_BLTZ    5'h00
`define OPC_RT_BGEZ    5'h01
`define OPC_RT_BLTZAL  5'h10
`define OPC_RT_BGEZAL  5'h11

// special funct codes
`define FN_SLL         6'd0
`define FN_SRL         6'd2
`define FN_SRA         6'd3
`define FN_SLLV        6'd4
`define FN_SRLV        6'd6
`define FN_SRAV        6'd7
`define FN_JR          6'd8
`define FN_JALR        6'd9
`define FN_ADD         6'd32
`define FN_ADDU        6'd33
`define FN_SUB         6'd34
`define FN_SUBU        6'd35
`define FN_AND         6'd36
`define FN_OR          6'd37
`define FN_XOR         6'd38
`define FN_NOR         6'd39
`define FN_SLT         6'd42
`define FN_SLTU        6'd43

`endif

/* hdl/idec_pkg.sv */
`include "idec_defines.svh"

package idec_pkg;

  typedef enum logic [3:0] {
    OP_PASS_A,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_NOR,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_LUI
  } alu_op_t;

  typedef enum logic {
    RES_ALU,
    RES_SET
  } alu_res_t;

  typedef enum logic [1:0] {
    OP_LS_WORD,
    OP_LS_HALFWORD,
    OP_LS_BYTE
  } ls_op_t;

  typedef enum logic [2:0] {
    COND_UNCONDITIONAL,
    COND_EQ,
    COND_NE,
    COND_LT,
    COND_GE,
    COND_LE,
    COND_GT
  } cond_t;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_FROM_EXMEM,
    FWD_FROM_MEMWB,
    FWD_FROM_MEMWB_LATE
  } fwd_t;

  typedef struct packed {
    logic [`IDEC_RA-1:0] num;
    logic                valid;
  } src_t;

  typedef struct packed {
    logic                alu_inst;
    logic                load_inst;
    logic                store_inst;
    logic                jmp_inst;
    logic                branch_inst;
    alu_op_t             alu_op;
    alu_res_t            alu_res_sel;
    logic                alu_set_u;
    ls_op_t              ls_op;
    logic                ls_sext;
    cond_t               branch_cond;
    logic [`IDEC_RA-1:0] dest_reg;
    logic                dest_reg_valid;
    logic                b_need_late;    // B only needed in MEM
    src_t                a_src;
    src_t                b_src;
    logic [`IDEC_RA-1:0] shamt;
  } dec_ctrl_t;

  typedef struct packed {
    logic [`IDEC_XLEN-1:0] a;
    logic [`IDEC_XLEN-1:0] b;
    logic [`IDEC_XLEN-1:0] imm;
    logic                  imm_valid;
    fwd_t                  a_fwd;
    fwd_t                  b_fwd;
  } opnd_t;

endpackage

/* hdl/imm_gen.sv */
`timescale 1ns/1ns
`include "idec_defines.svh"

module imm_gen (
  input  logic [`IDEC_XLEN-1:0] inst_word,
  input  logic [`IDEC_XLEN-1:0] pc_plus_4,
  input  logic                  jmp,
  input  logic                  branch,
  input  logic                  sext,
  output logic [`IDEC_XLEN-1:0] imm
);

  logic [15:0] imm16;
  logic [25:0] addr;

  assign imm16 = inst_word[`IDEC_F_IMM];
  assign addr  = inst_word[`IDEC_F_ADDR];

  always_comb begin
    if (jmp)
      imm = {pc_plus_4[`IDEC_XLEN-1 -: 4], addr, 2'b00};  // same 256M region
    else if (branch)
      imm = pc_plus_4 + {{(`IDEC_XLEN-18){imm16[15]}}, imm16, 2'b00};
    else if (sext)
      imm = {{(`IDEC_XLEN-16){imm16[15]}}, imm16};
    else
      imm = {{(`IDEC_XLEN-16){1'b0}}, imm16};
  end

endmodule

/* hdl/inst_decoder.sv */
`timescale 1ns/1ns
`include "idec_defines.svh"

module inst_decoder import idec_pkg::*; (
  input  logic [`IDEC_XLEN-1:0] inst_word,
  output dec_ctrl_t             ctrl,
  output logic                  imm_sext,
  output logic                  imm_valid
);

  logic [5:0]          opc;
  logic [5:0]          funct;
  logic [`IDEC_RA-1:0] rs;
  logic [`IDEC_RA-1:0] rt;
  logic [`IDEC_RA-1:0] rd;
  logic [`IDEC_RA-1:0] shamt;

  assign opc   = inst_word[`IDEC_F_OPC];
  assign funct = inst_word[`IDEC_F_FUNCT];
  assign rs    = inst_word[`IDEC_F_RS];
  assign rt    = inst_word[`IDEC_F_RT];
  assign rd    = inst_word[`IDEC_F_RD];
  assign shamt = inst_word[`IDEC_F_SHAMT];

  always_comb begin
    ctrl                = '0;  // pass A, word, unconditional
    ctrl.a_src.num      = rs;
    ctrl.b_src.num      = rt;
    ctrl.dest_reg       = rt;
    ctrl.dest_reg_valid = 1'b1;
    imm_sext            = 1'b0;
    imm_valid           = 1'b1;   // I-format unless told otherwise

    case (opc)
      `OPC_SPECIAL: begin
        imm_valid        = 1'b0;
        ctrl.dest_reg    = rd;
        ctrl.shamt       = shamt;
        ctrl.alu_inst    = 1'b1;
        ctrl.a_src.valid = 1'b1;
        ctrl.b_src.valid = 1'b1;
        case (funct)
          `FN_SLL, `FN_SLLV: ctrl.alu_op = OP_SLL;
          `FN_SRL, `FN_SRLV: ctrl.alu_op = OP_SRL;
          `FN_SRA, `FN_SRAV: ctrl.alu_op = OP_SRA;
          `FN_ADD, `FN_ADDU: ctrl.alu_op = OP_ADD;
          `FN_SUB, `FN_SUBU: ctrl.alu_op = OP_SUB;
          `FN_AND:           ctrl.alu_op = OP_AND;
          `FN_OR:            ctrl.alu_op = OP_OR;
          `FN_XOR:           ctrl.alu_op = OP_XOR;
          `FN_NOR:           ctrl.alu_op = OP_NOR;
          `FN_SLT, `FN_SLTU: begin
            ctrl.alu_op      = OP_SUB;
            ctrl.alu_res_sel = RES_SET;
            ctrl.alu_set_u   = funct[0];  // sltu
          end
          `FN_JR, `FN_JALR: begin
            ctrl.alu_inst       = 1'b0;
            ctrl.jmp_inst       = 1'b1;
            ctrl.b_src.valid    = 1'b0;
            ctrl.dest_reg_valid = funct[0];  // jalr links via rd
          end
          default: begin
            ctrl.alu_inst       = 1'b0;
            ctrl.a_src.valid    = 1'b0;
            ctrl.b_src.valid    = 1'b0;
            ctrl.dest_reg_valid = 1'b0;
          end
        endcase
        // constant shifts take no rs
        if (funct == `FN_SLL || funct == `FN_SRL || funct == `FN_SRA)
          ctrl.a_src.valid = 1'b0;
      end

      `OPC_REGIMM: begin
        ctrl.branch_inst    = 1'b1;
        ctrl.a_src.valid    = 1'b1;
        ctrl.dest_reg       = `IDEC_LINK_REG;
        ctrl.dest_reg_valid = rt[4];  // the -al forms
        case (rt)
          `OPC_RT_BLTZ, `OPC_RT_BLTZAL: ctrl.branch_cond = COND_LT;
          `OPC_RT_BGEZ, `OPC_RT_BGEZAL: ctrl.branch_cond = COND_GE;
          default: begin
            ctrl.branch_inst    = 1'b0;
            ctrl.a_src.valid    = 1'b0;
            ctrl.dest_reg_valid = 1'b0;
          end
        endcase
      end

      `OPC_J: begin
        ctrl.jmp_inst       = 1'b1;
        ctrl.dest_reg_valid = 1'b0;
      end

      `OPC_JAL: begin
        ctrl.jmp_inst = 1'b1;
        ctrl.dest_reg = `IDEC_LINK_REG;
      end

      `OPC_BEQ, `OPC_BNE, `OPC_BLEZ, `OPC_BGTZ: begin
        ctrl.branch_inst    = 1'b1;
        ctrl.dest_reg_valid = 1'b0;
        ctrl.a_src.valid    = 1'b1;
        ctrl.b_src.valid    = !opc[1];  // blez/bgtz compare to zero
        case (opc[1:0])
          2'b00:   ctrl.branch_cond = COND_EQ;
          2'b01:   ctrl.branch_cond = COND_NE;
          2'b10:   ctrl.branch_cond = COND_LE;
          default: ctrl.branch_cond = COND_GT;
        endcase
      end

      `OPC_ADDI, `OPC_ADDIU: begin
        ctrl.alu_inst    = 1'b1;
        ctrl.alu_op      = OP_ADD;
        ctrl.a_src.valid = 1'b1;
        imm_sext         = 1'b1;
      end

      `OPC_SLTI, `OPC_SLTIU: begin
        ctrl.alu_inst    = 1'b1;
        ctrl.alu_op      = OP_SUB;
        ctrl.alu_res_sel = RES_SET;
        ctrl.alu_set_u   = opc[0];
        ctrl.a_src.valid = 1'b1;
        imm_sext         = 1'b1;
      end

      `OPC_ANDI, `OPC_ORI, `OPC_XORI: begin
        ctrl.alu_inst    = 1'b1;
        ctrl.a_src.valid = 1'b1;
        case (opc[1:0])
          2'b00:   ctrl.alu_op = OP_AND;
          2'b01:   ctrl.alu_op = OP_OR;
          default: ctrl.alu_op = OP_XOR;
        endcase
      end

      `OPC_LUI: begin
        ctrl.alu_inst = 1'b1;
        ctrl.alu_op   = OP_LUI;
      end

      `OPC_LB, `OPC_LH, `OPC_LW, `OPC_LBU, `OPC_LHU,
      `OPC_SB, `OPC_SH, `OPC_SW: begin
        ctrl.alu_op         = OP_ADD;  // base + offset
        ctrl.a_src.valid    = 1'b1;
        imm_sext            = 1'b1;
        ctrl.load_inst      = !opc[3];
        ctrl.store_inst     = opc[3];
        ctrl.b_src.valid    = opc[3];
        ctrl.b_need_late    = opc[3];  // store data is read in MEM
        ctrl.dest_reg_valid = !opc[3];
        ctrl.ls_sext        = !opc[3] && (opc[2:1] == 2'b00);  // lb, lh
        case (opc[1:0])
          2'b00:   ctrl.ls_op = OP_LS_BYTE;
          2'b01:   ctrl.ls_op = OP_LS_HALFWORD;
          default: ctrl.ls_op = OP_LS_WORD;
        endcase
      end

      default: ctrl.dest_reg_valid = 1'b0;
    endcase

    // $0 is never written nor forwarded
    if (ctrl.dest_reg == '0)
      ctrl.dest_reg_valid = 1'b0;
  end

  a_class_onehot: assert final ($onehot0({ctrl.alu_inst, ctrl.load_inst, ctrl.store_inst,
                                          ctrl.jmp_inst, ctrl.branch_inst}));

endmodule

/* hdl/stage_reg.sv */
`timescale 1ns/1ns

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     bubble,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk) begin
    if (!rst_n || bubble)
      q <= '0;  // bubble leaves nothing valid downstream
    else
      q <= d;
  end

  a_bubble_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    bubble |=> (q == '0)
  );

endmodule

/* sim/clk_gen.sv */
`timescale 1ns/1ns

module clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;  // released on a rising edge
  end

endmodule

/* sim/tb_idec.sv */
`timescale 1ns/1ns
`include "idec_defines.svh"

module tb_idec import idec_pkg::*; ();

  typedef struct packed {
    dec_ctrl_t  ctrl;
    opnd_t      opnd;
    logic       stall;
    logic [1:0] cls;  // 0 alu, 1 jump/branch, 2 load/store, 3 unknown
  } expect_t;

  localparam int N_CYCLES    = 4000;
  localparam int WATCHDOG_NS = 200_000;

  logic                  clk;
  logic                  rst_n;
  logic [`IDEC_XLEN-1:0] inst_word;
  logic [`IDEC_XLEN-1:0] pc_plus_4;
  logic [`IDEC_XLEN-1:0] rd_data1;
  logic [`IDEC_XLEN-1:0] rd_data2;
  src_t                  ex_dest;
  src_t                  mem_dest;
  logic                  ex_load;
  logic [`IDEC_RA-1:0]   rd_addr1;
  logic [`IDEC_RA-1:0]   rd_addr2;
  logic                  stall;
  dec_ctrl_t             ctrl;
  opnd_t                 opnd;

  expect_t exp_q[$];
  int      checks[1:6];
  int      errors[1:6];
  int      n_stall;
  int      n_late_store;
  bit      timed_out;

  // {opcode, funct or regimm rt}
  logic [11:0] sup_tab [44] = '{
    {`OPC_SPECIAL, `FN_SLL}, {`OPC_SPECIAL, `FN_SRL}, {`OPC_SPECIAL, `FN_SRA},
    {`OPC_SPECIAL, `FN_SLLV}, {`OPC_SPECIAL, `FN_SRLV}, {`OPC_SPECIAL, `FN_SRAV},
    {`OPC_SPECIAL, `FN_JR}, {`OPC_SPECIAL, `FN_JALR}, {`OPC_SPECIAL, `FN_ADD},
    {`OPC_SPECIAL, `FN_ADDU}, {`OPC_SPECIAL, `FN_SUB}, {`OPC_SPECIAL, `FN_SUBU},
    {`OPC_SPECIAL, `FN_AND}, {`OPC_SPECIAL, `FN_OR}, {`OPC_SPECIAL, `FN_XOR},
    {`OPC_SPECIAL, `FN_NOR}, {`OPC_SPECIAL, `FN_SLT}, {`OPC_SPECIAL, `FN_SLTU},
    {`OPC_REGIMM, 1'b0, `OPC_RT_BLTZ}, {`OPC_REGIMM, 1'b0, `OPC_RT_BGEZ},
    {`OPC_REGIMM, 1'b0, `OPC_RT_BLTZAL}, {`OPC_REGIMM, 1'b0, `OPC_RT_BGEZAL},
    {`OPC_J, 6'h0}, {`OPC_JAL, 6'h0}, {`OPC_BEQ, 6'h0}, {`OPC_BNE, 6'h0},
    {`OPC_BLEZ, 6'h0}, {`OPC_BGTZ, 6'h0}, {`OPC_ADDI, 6'h0}, {`OPC_ADDIU, 6'h0},
    {`OPC_SLTI, 6'h0}, {`OPC_SLTIU, 6'h0}, {`OPC_ANDI, 6'h0}, {`OPC_ORI, 6'h0},
    {`OPC_XORI, 6'h0}, {`OPC_LUI, 6'h0}, {`OPC_LB, 6'h0}, {`OPC_LH, 6'h0},
    {`OPC_LW, 6'h0}, {`OPC_LBU, 6'h0}, {`OPC_LHU, 6'h0}, {`OPC_SB, 6'h0},
    {`OPC_SH, 6'h0}, {`OPC_SW, 6'h0}
  };

  // mfhi..mtlo, mult..divu, then other undefined encodings
  logic [11:0] unk_tab [15] = '{
    {`OPC_SPECIAL, 6'h10}, {`OPC_SPECIAL, 6'h11}, {`OPC_SPECIAL, 6'h12},
    {`OPC_SPECIAL, 6'h13}, {`OPC_SPECIAL, 6'h18}, {`OPC_SPECIAL, 6'h19},
    {`OPC_SPECIAL, 6'h1a}, {`OPC_SPECIAL, 6'h1b}, {`OPC_SPECIAL, 6'h01},
    {`OPC_SPECIAL, 6'h0c}, {`OPC_REGIMM, 6'h02}, {`OPC_REGIMM, 6'h13},
    {6'h10, 6'h0}, {6'h22, 6'h0}, {6'h3f, 6'h0}
  };

  clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

  idec idec_i (
    .clk, .rst_n, .inst_word, .pc_plus_4, .rd_data1, .rd_data2,
    .ex_dest, .mem_dest, .ex_load, .rd_addr1, .rd_addr2, .stall, .ctrl, .opnd
  );

  // mostly small register numbers to make hazards frequent
  function automatic logic [4:0] pick_reg();
    return ($urandom_range(3) != 0) ? 5'($urandom_range(3)) : 5'($urandom);
  endfunction

  function automatic logic [31:0] random_inst();
    logic [11:0] code;
    logic [31:0] w;
    code = ($urandom_range(9) != 0) ? sup_tab[$urandom_range(43)] : unk_tab[$urandom_range(14)];
    w = {code[11:6], pick_reg(), pick_reg(), 16'($urandom)};
    if (code[11:6] == `OPC_SPECIAL)
      w = {w[31:16], pick_reg(), w[10:6], code[5:0]};
    else if (code[11:6] == `OPC_REGIMM)
      w[20:16] = code[4:0];
    return w;
  endfunction

  task automatic drive_random();
    inst_word <= random_inst();
    pc_plus_4 <= {30'($urandom), 2'b00};
    rd_data1  <= $urandom;
    rd_data2  <= $urandom;
    ex_dest   <= '{num: pick_reg(), valid: 1'($urandom)};
    mem_dest  <= '{num: pick_reg(), valid: 1'($urandom)};
    ex_load   <= ($urandom_range(2) == 0);
  endtask

  function automatic expect_t decode_model();
    expect_t    e;
    logic [5:0] opc;
    logic [5:0] fn;
    logic       use_a;
    logic       use_b;
    logic       wr;
    logic       sext;
    logic       a_ex;
    logic       a_mem;
    logic       b_ex;
    logic       b_mem;
    opc   = inst_word[31:26];
    fn    = inst_word[5:0];
    e     = '0;
    use_a = 1'b1;
    use_b = 1'b0;
    wr    = 1'b1;
    sext  = 1'b0;
    e.ctrl.a_src.num = inst_word[25:21];
    e.ctrl.b_src.num = inst_word[20:16];
    e.ctrl.dest_reg  = inst_word[20:16];
    e.opnd.imm_valid = (opc != `OPC_SPECIAL);
    case (opc)
      `OPC_SPECIAL: begin
        e.ctrl.dest_reg = inst_word[15:11];
        e.ctrl.shamt    = inst_word[10:6];
        e.ctrl.alu_inst = 1'b1;
        use_b           = 1'b1;
        case (fn)
          `FN_SLL, `FN_SLLV: e.ctrl.alu_op = OP_SLL;
          `FN_SRL, `FN_SRLV: e.ctrl.alu_op = OP_SRL;
          `FN_SRA, `FN_SRAV: e.ctrl.alu_op = OP_SRA;
          `FN_ADD, `FN_ADDU: e.ctrl.alu_op = OP_ADD;
          `FN_SUB, `FN_SUBU: e.ctrl.alu_op = OP_SUB;
          `FN_AND:           e.ctrl.alu_op = OP_AND;
          `FN_OR:            e.ctrl.alu_op = OP_OR;
          `FN_XOR:           e.ctrl.alu_op = OP_XOR;
          `FN_NOR:           e.ctrl.alu_op = OP_NOR;
          `FN_SLT, `FN_SLTU: begin
            e.ctrl.alu_op      = OP_SUB;
            e.ctrl.alu_res_sel = RES_SET;
            e.ctrl.alu_set_u   = (fn == `FN_SLTU);
          end
          `FN_JR, `FN_JALR: begin
            e.ctrl.alu_inst = 1'b0;
            e.ctrl.jmp_inst = 1'b1;
            e.cls           = 2'd1;
            use_b           = 1'b0;
            wr              = (fn == `FN_JALR);
          end
          default: begin
            e.ctrl.alu_inst = 1'b0;
            e.cls           = 2'd3;
            use_a           = 1'b0;
            use_b           = 1'b0;
            wr              = 1'b0;
          end
        endcase
        if (fn inside {`FN_SLL, `FN_SRL, `FN_SRA})
          use_a = 1'b0;  // shift by shamt
      end
      `OPC_REGIMM: begin
        e.ctrl.dest_reg    = `IDEC_LINK_REG;
        e.ctrl.branch_inst = 1'b1;
        e.cls              = 2'd1;
        wr                 = (inst_word[20:16] inside {`OPC_RT_BLTZAL, `OPC_RT_BGEZAL});
        case (inst_word[20:16])
          `OPC_RT_BLTZ, `OPC_RT_BLTZAL: e.ctrl.branch_cond = COND_LT;
          `OPC_RT_BGEZ, `OPC_RT_BGEZAL: e.ctrl.branch_cond = COND_GE;
          default: begin
            e.ctrl.branch_inst = 1'b0;
            e.cls              = 2'd3;
            use_a              = 1'b0;
            wr                 = 1'b0;
          end
        endcase
      end
      `OPC_J, `OPC_JAL: begin
        e.ctrl.jmp_inst = 1'b1;
        e.cls           = 2'd1;
        use_a           = 1'b0;
        wr              = (opc == `OPC_JAL);
        if (opc == `OPC_JAL)
          e.ctrl.dest_reg = `IDEC_LINK_REG;
      end
      `OPC_BEQ, `OPC_BNE, `OPC_BLEZ, `OPC_BGTZ: begin
        e.ctrl.branch_inst = 1'b1;
        e.cls              = 2'd1;
        wr                 = 1'b0;
        use_b              = (opc == `OPC_BEQ || opc == `OPC_BNE);
        if (opc == `OPC_BEQ)
          e.ctrl.branch_cond = COND_EQ;
        else if (opc == `OPC_BNE)
          e.ctrl.branch_cond = COND_NE;
        else if (opc == `OPC_BLEZ)
          e.ctrl.branch_cond = COND_LE;
        else
          e.ctrl.branch_cond = COND_GT;
      end
      `OPC_ADDI, `OPC_ADDIU, `OPC_SLTI, `OPC_SLTIU: begin
        e.ctrl.alu_inst = 1'b1;
        sext            = 1'b1;
        e.ctrl.alu_op   = (opc inside {`OPC_ADDI, `OPC_ADDIU}) ? OP_ADD : OP_SUB;
        if (opc inside {`OPC_SLTI, `OPC_SLTIU})
          e.ctrl.alu_res_sel = RES_SET;
        e.ctrl.alu_set_u = (opc == `OPC_SLTIU);
      end
      `OPC_ANDI: begin
        e.ctrl.alu_inst = 1'b1;
        e.ctrl.alu_op   = OP_AND;
      end
      `OPC_ORI: begin
        e.ctrl.alu_inst = 1'b1;
        e.ctrl.alu_op   = OP_OR;
      end
      `OPC_XORI: begin
        e.ctrl.alu_inst = 1'b1;
        e.ctrl.alu_op   = OP_XOR;
      end
      `OPC_LUI: begin
        e.ctrl.alu_inst = 1'b1;
        e.ctrl.alu_op   = OP_LUI;
        use_a           = 1'b0;
      end
      `OPC_LB, `OPC_LH, `OPC_LW, `OPC_LBU, `OPC_LHU, `OPC_SB, `OPC_SH, `OPC_SW: begin
        e.cls              = 2'd2;
        e.ctrl.alu_op      = OP_ADD;
        sext               = 1'b1;
        e.ctrl.store_inst  = (opc inside {`OPC_SB, `OPC_SH, `OPC_SW});
        e.ctrl.load_inst   = !e.ctrl.store_inst;
        e.ctrl.ls_sext     = (opc inside {`OPC_LB, `OPC_LH});
        e.ctrl.b_need_late = e.ctrl.store_inst;
        use_b              = e.ctrl.store_inst;
        wr                 = e.ctrl.load_inst;
        if (opc inside {`OPC_LB, `OPC_LBU, `OPC_SB})
          e.ctrl.ls_op = OP_LS_BYTE;
        else if (opc inside {`OPC_LH, `OPC_LHU, `OPC_SH})
          e.ctrl.ls_op = OP_LS_HALFWORD;
        else
          e.ctrl.ls_op = OP_LS_WORD;
      end
      default: begin
        e.cls = 2'd3;
        use_a = 1'b0;
        wr    = 1'b0;
      end
    endcase
    e.ctrl.a_src.valid    = use_a;
    e.ctrl.b_src.valid    = use_b;
    e.ctrl.dest_reg_valid = wr && (e.ctrl.dest_reg != 5'd0);
    if (e.ctrl.jmp_inst)
      e.opnd.imm = {pc_plus_4[31:28], inst_word[25:0], 2'b00};
    else if (e.ctrl.branch_inst)
      e.opnd.imm = pc_plus_4 + {{14{inst_word[15]}}, inst_word[15:0], 2'b00};
    else if (sext)
      e.opnd.imm = {{16{inst_word[15]}}, inst_word[15:0]};
    else
      e.opnd.imm = {16'h0, inst_word[15:0]};
    e.opnd.a = rd_data1;
    e.opnd.b = rd_data2;
    a_ex  = use_a && ex_dest.valid && (inst_word[25:21] == ex_dest.num);
    a_mem = use_a && mem_dest.valid && (inst_word[25:21] == mem_dest.num);
    b_ex  = use_b && ex_dest.valid && (inst_word[20:16] == ex_dest.num);
    b_mem = use_b && mem_dest.valid && (inst_word[20:16] == mem_dest.num);
    e.opnd.a_fwd = a_ex ? FWD_FROM_EXMEM : (a_mem ? FWD_FROM_MEMWB : FWD_NONE);
    if (b_ex)
      e.opnd.b_fwd = ex_load ? FWD_FROM_MEMWB_LATE : FWD_FROM_EXMEM;
    else
      e.opnd.b_fwd = b_mem ? FWD_FROM_MEMWB : FWD_NONE;
    e.stall = ex_load && (a_ex || (b_ex && !e.ctrl.b_need_late));
    return e;
  endfunction

  task automatic mismatch(input int t, input string name, input logic [127:0] got,
                          input logic [127:0] want);
    $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
    errors[t]++;
  endtask

  task automatic check_registered(input expect_t e);
    dec_ctrl_t x;
    opnd_t     o;
    int        fb;
    x  = e.ctrl;
    o  = e.opnd;
    fb = (e.cls == 2'd0) ? 2 : ((e.cls == 2'd1) ? 3 : 4);  // class owns flags and dest
    if (e.stall) begin
      checks[6]++;
      if (ctrl !== '0)
        mismatch(6, "ctrl after stall", ctrl, 0);
      if (opnd !== '0)
        mismatch(6, "opnd after stall", opnd, 0);
    end else begin
      for (int t = 2; t <= 5; t++)
        checks[t]++;
      if (ctrl.alu_inst !== x.alu_inst)
        mismatch(fb, "ctrl.alu_inst", ctrl.alu_inst, x.alu_inst);
      if (ctrl.load_inst !== x.load_inst)
        mismatch(fb, "ctrl.load_inst", ctrl.load_inst, x.load_inst);
      if (ctrl.store_inst !== x.store_inst)
        mismatch(fb, "ctrl.store_inst", ctrl.store_inst, x.store_inst);
      if (ctrl.jmp_inst !== x.jmp_inst)
        mismatch(fb, "ctrl.jmp_inst", ctrl.jmp_inst, x.jmp_inst);
      if (ctrl.branch_inst !== x.branch_inst)
        mismatch(fb, "ctrl.branch_inst", ctrl.branch_inst, x.branch_inst);
      if (ctrl.dest_reg !== x.dest_reg)
        mismatch(fb, "ctrl.dest_reg", ctrl.dest_reg, x.dest_reg);
      if (ctrl.dest_reg_valid !== x.dest_reg_valid)
        mismatch(fb, "ctrl.dest_reg_valid", ctrl.dest_reg_valid, x.dest_reg_valid);
      if (ctrl.alu_op !== x.alu_op)
        mismatch(2, "ctrl.alu_op", ctrl.alu_op, x.alu_op);
      if (ctrl.alu_res_sel !== x.alu_res_sel)
        mismatch(2, "ctrl.alu_res_sel", ctrl.alu_res_sel, x.alu_res_sel);
      if (ctrl.alu_set_u !== x.alu_set_u)
        mismatch(2, "ctrl.alu_set_u", ctrl.alu_set_u, x.alu_set_u);
      if (ctrl.shamt !== x.shamt)
        mismatch(2, "ctrl.shamt", ctrl.shamt, x.shamt);
      if (ctrl.a_src !== x.a_src)
        mismatch(2, "ctrl.a_src", ctrl.a_src, x.a_src);
      if (ctrl.b_src !== x.b_src)
        mismatch(2, "ctrl.b_src", ctrl.b_src, x.b_src);
      if (opnd.imm !== o.imm)
        mismatch(3, "opnd.imm", opnd.imm, o.imm);
      if (opnd.imm_valid !== o.imm_valid)
        mismatch(3, "opnd.imm_valid", opnd.imm_valid, o.imm_valid);
      if (ctrl.branch_cond !== x.branch_cond)
        mismatch(3, "ctrl.branch_cond", ctrl.branch_cond, x.branch_cond);
      if (ctrl.ls_op !== x.ls_op)
        mismatch(4, "ctrl.ls_op", ctrl.ls_op, x.ls_op);
      if (ctrl.ls_sext !== x.ls_sext)
        mismatch(4, "ctrl.ls_sext", ctrl.ls_sext, x.ls_sext);
      if (ctrl.b_need_late !== x.b_need_late)
        mismatch(4, "ctrl.b_need_late", ctrl.b_need_late, x.b_need_late);
      if (opnd.a_fwd !== o.a_fwd)
        mismatch(5, "opnd.a_fwd", opnd.a_fwd, o.a_fwd);
      if (opnd.b_fwd !== o.b_fwd)
        mismatch(5, "opnd.b_fwd", opnd.b_fwd, o.b_fwd);
      if (opnd.a !== o.a)
        mismatch(5, "opnd.a", opnd.a, o.a);
      if (opnd.b !== o.b)
        mismatch(5, "opnd.b", opnd.b, o.b);
    end
  endtask

  task automatic reset_phase();
    int cyc;
    cyc = 0;
    @(posedge clk);
    do begin
      @(negedge clk);
      cyc++;
      checks[1]++;
      if (ctrl !== '0)
        mismatch(1, "ctrl in reset", ctrl, 0);
      if (opnd !== '0)
        mismatch(1, "opnd in reset", opnd, 0);
      if (cyc > 20)
        timed_out = 1'b1;
    end while (!rst_n && !timed_out);
    if (timed_out)
      $display("Reset was still asserted after 20 cycles");
  endtask

  task automatic print_result(input int t, input string name);
    $display("test %0d %-28s %0d checks, %0d errors", t, name, checks[t], errors[t]);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    expect_t e;
    int      n_checks;
    int      n_errors;
    inst_word = 32'hfc00_0000;  // undefined opcode
    pc_plus_4 = '0;
    rd_data1  = '0;
    rd_data2  = '0;
    ex_dest   = '0;
    mem_dest  = '0;
    ex_load   = 1'b0;
    reset_phase();
    print_result(1, "reset");
    void'($urandom(83));
    exp_q.push_back(decode_model());  // value loaded on the release edge
    for (int n = 0; n < N_CYCLES && !timed_out; n++) begin
      @(posedge clk);
      drive_random();
      @(negedge clk);
      check_registered(exp_q.pop_front());
      e = decode_model();
      checks[2]++;
      checks[6]++;
      if (rd_addr1 !== e.ctrl.a_src.num)
        mismatch(2, "rd_addr1", rd_addr1, e.ctrl.a_src.num);
      if (rd_addr2 !== e.ctrl.b_src.num)
        mismatch(2, "rd_addr2", rd_addr2, e.ctrl.b_src.num);
      if (stall !== e.stall)
        mismatch(6, "stall", stall, e.stall);
      n_stall      += e.stall;
      n_late_store += e.ctrl.store_inst && !e.stall && (e.opnd.b_fwd == FWD_FROM_MEMWB_LATE);
      exp_q.push_back(e);
    end
    print_result(2, "ALU and shift decode");
    print_result(3, "immediates and control flow");
    print_result(4, "loads, stores and unknown");
    print_result(5, "forwarding");
    print_result(6, "stall and bubble");
    n_checks = 0;
    n_errors = 0;
    for (int t = 1; t <= 6; t++) begin
      n_checks += checks[t];
      n_errors += errors[t];
    end
    $display("total %0d checks, %0d errors, %0d stalls, %0d stores on late forward",
             n_checks, n_errors, n_stall, n_late_store);
    if (n_errors == 0 && !timed_out)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hdl
hdl/idec_pkg.sv
hdl/inst_decoder.sv
hdl/imm_gen.sv
hdl/hazard_unit.sv
hdl/stage_reg.sv
hdl/idec.sv
sim/clk_gen.sv
sim/tb_idec.sv
